/* hdl/bus_pkg.sv */
// host bus definitions
package bus_pkg;

    ////////////////////////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////////////////////////

    localparam int BUS_ADDR_W = 16;     // byte address
    localparam int BUS_DATA_W = 16;
    localparam int BUS_LANES  = 2;      // one write strobe per byte lane

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////

    // sample buffer window $d000..$d3ff, byte accessible
    localparam logic [BUS_ADDR_W-1:0] BUF_BASE = 16'hD000;
    localparam int BUF_WINDOW_BITS = 10;    // low bits decoded inside the window

    // playback control port in the io page
    localparam logic [BUS_ADDR_W-1:0] WAVCTL_ADDR = 16'hFF1E;

    ////////////////////////////////////////////////////////////
    // control register layout
    ////////////////////////////////////////////////////////////

    localparam int CTL_EN_BIT   = 0;    // playback enable
    localparam int CTL_AB_BIT   = 1;    // active half, 0 = A
    localparam int CTL_RATE_LSB = 2;    // rate code in bits 3..2
    localparam int CTL_W        = 4;

endpackage

/* hdl/wav_pkg.sv */
// sample playback definitions
package wav_pkg;

    ////////////////////////////////////////////////////////////
    // clock and sample rates
    ////////////////////////////////////////////////////////////

    localparam logic [31:0] CLK_HZ = 32'd24_000_000;

    localparam int RATE_HZ_44100 = 44100;
    localparam int RATE_HZ_22050 = 22050;
    localparam int RATE_HZ_48000 = 48000;

    // truncated quotients, close enough for tape loading
    localparam int DIV_44100 = CLK_HZ / RATE_HZ_44100;    // 544
    localparam int DIV_22050 = CLK_HZ / RATE_HZ_22050;    // 1088
    localparam int DIV_48000 = CLK_HZ / RATE_HZ_48000;    // 500
    localparam int DIV_W     = 11;                        // holds up to 1087

    ////////////////////////////////////////////////////////////
    // buffer geometry
    ////////////////////////////////////////////////////////////

    localparam int SAMPLE_W    = 8;     // unsigned 8-bit pcm
    localparam int HALF_ADDR_W = 9;     // 512 bytes per half
    localparam int BUF_ADDR_W  = 10;    // {half, position}

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        RATE_44100     = 2'd0,
        RATE_22050     = 2'd1,
        RATE_48000     = 2'd2,
        RATE_48000_ALT = 2'd3       // bit 3 alone selects 48k
    } rate_sel_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,                 // request pending, waiting for a free bus
        FETCH_CAPTURE               // buffer byte valid this cycle
    } fetch_state_t;

endpackage

/* hdl/sample_rate_divider.sv */
// sample tick divider
`timescale 1ns/1ps

module sample_rate_divider
    import wav_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  rate_sel_t i_rate,
    output logic      o_tick
);

    logic [DIV_W-1:0] div_cnt;
    logic [DIV_W-1:0] div_top;     // last count value of the period

    // period select, both 48k codes share a divisor
    always_comb
    begin
        case (i_rate)
            RATE_44100:     div_top = DIV_W'(DIV_44100 - 1);
            RATE_22050:     div_top = DIV_W'(DIV_22050 - 1);
            RATE_48000:     div_top = DIV_W'(DIV_48000 - 1);
            RATE_48000_ALT: div_top = DIV_W'(DIV_48000 - 1);
            default:        div_top = DIV_W'(DIV_44100 - 1);
        endcase
    end

    // free running, never restarted by a control write
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            div_cnt <= '0;
        else if (div_cnt >= div_top)    // also catches a switch to a shorter period
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign o_tick = (div_cnt == '0);   // one cycle per period

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // counter must never run past the longest period
    a_cnt_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        div_cnt < DIV_W'(DIV_22050)
    );

endmodule

/* hdl/wav_ctl_regs.sv */
// playback control register
`timescale 1ns/1ps

module wav_ctl_regs
    import bus_pkg::*;
    import wav_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    // host bus
    input  logic [BUS_ADDR_W-1:0] i_bus_addr,
    input  logic [BUS_LANES-1:0]  i_bus_wr,
    input  logic                  i_bus_rd,
    input  logic [BUS_DATA_W-1:0] i_bus_wdata,

    // from the fetch fsm
    input  logic                  i_half_wrap,

    // decoded control
    output logic                  o_ctl_wr,
    output logic                  o_enable,
    output logic                  o_active_half,
    output rate_sel_t             o_rate,

    // gated read-back
    output logic [BUS_DATA_W-1:0] o_ctl_rdata
);

    logic             ctl_sel;
    logic [CTL_W-1:0] ctl_q;       // {rate[1:0], a/b, enable}
    logic             ctl_rd_q;    // read strobe delayed to the data cycle

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    assign ctl_sel  = (i_bus_addr == WAVCTL_ADDR);
    assign o_ctl_wr = ctl_sel & i_bus_wr[0];   // low lane only

    ////////////////////////////////////////////////////////////
    // register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ctl_q <= '0;                        // disabled, half A, 44100
        end
        else if (o_ctl_wr)
        begin
            // host write beats a wrap in the same cycle
            ctl_q <= i_bus_wdata[CTL_W-1:0];
        end
        else if (i_half_wrap)
        begin
            ctl_q[CTL_AB_BIT] <= ~ctl_q[CTL_AB_BIT];    // hand the old half back
        end
    end

    assign o_enable      = ctl_q[CTL_EN_BIT];
    assign o_active_half = ctl_q[CTL_AB_BIT];
    assign o_rate        = rate_sel_t'(ctl_q[CTL_RATE_LSB +: $bits(rate_sel_t)]);

    ////////////////////////////////////////////////////////////
    // read-back
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            ctl_rd_q <= 1'b0;
        else
            ctl_rd_q <= ctl_sel & i_bus_rd;
    end

    // zero unless this port was read last cycle, so the top can OR sources
    assign o_ctl_rdata = ctl_rd_q ? {{(BUS_DATA_W-CTL_W){1'b0}}, ctl_q} : '0;

endmodule

/* hdl/sample_fetch_fsm.sv */
// play position and sample fetch
`timescale 1ns/1ps

module sample_fetch_fsm
    import wav_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    // timing and control
    input  logic                  i_tick,
    input  logic                  i_enable,
    input  logic                  i_ctl_wr,
    input  logic                  i_active_half,

    // buffer side
    input  logic                  i_host_busy,
    input  logic [SAMPLE_W-1:0]   i_play_byte,
    output logic                  o_play_rd,
    output logic [BUF_ADDR_W-1:0] o_play_addr,

    // to the control register
    output logic                  o_half_wrap,

    // audio out
    output logic [SAMPLE_W-1:0]   o_wav_sample
);

    logic [HALF_ADDR_W-1:0] play_pos;
    logic [HALF_ADDR_W-1:0] play_pos_next;
    logic                   play_step;     // tick while enabled
    fetch_state_t           state;
    fetch_state_t           state_next;

    ////////////////////////////////////////////////////////////
    // play position
    ////////////////////////////////////////////////////////////

    assign play_step     = i_tick & i_enable;
    assign play_pos_next = play_pos + 1'b1;
    assign o_half_wrap   = play_step & (play_pos_next == '0);  // end of the half

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            play_pos <= '0;
        else if (i_ctl_wr)
            play_pos <= '0;                 // restart on any control write
        else if (play_step)
            play_pos <= play_pos_next;
    end

    ////////////////////////////////////////////////////////////
    // fetch fsm
    ////////////////////////////////////////////////////////////

    // read goes out only on a cycle the host leaves alone
    assign o_play_rd   = (state == FETCH_WAIT) & ~i_host_busy;
    assign o_play_addr = {i_active_half, play_pos};

    always_comb
    begin
        state_next = state;
        case (state)
            FETCH_IDLE:
                if (play_step)
                    state_next = FETCH_WAIT;
            FETCH_WAIT:
                if (play_step)
                    state_next = FETCH_WAIT;    // newer position, refetch
                else if (!i_host_busy)
                    state_next = FETCH_CAPTURE;
            FETCH_CAPTURE:
                state_next = play_step ? FETCH_WAIT : FETCH_IDLE;
            default:
                state_next = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= FETCH_IDLE;
        else
            state <= state_next;
    end

    // sample register, holds between fetches
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            o_wav_sample <= '0;
        else if (state == FETCH_CAPTURE)
            o_wav_sample <= i_play_byte;
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_rd_bus_free: assert property (
        @(posedge clk) disable iff (!reset_n)
        o_play_rd |-> !i_host_busy
    );

endmodule

/* hdl/sample_buffer.sv */
// ping-pong sample buffer
`timescale 1ns/1ps

module sample_buffer
    import bus_pkg::*;
    import wav_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    // host bus
    input  logic [BUS_ADDR_W-1:0] i_bus_addr,
    input  logic [BUS_LANES-1:0]  i_bus_wr,
    input  logic                  i_bus_rd,
    input  logic [BUS_DATA_W-1:0] i_bus_wdata,

    // playback port
    input  logic                  i_play_rd,
    input  logic [BUF_ADDR_W-1:0] i_play_addr,

    output logic                  o_host_busy,
    output logic [BUS_DATA_W-1:0] o_buf_rdata,
    output logic [SAMPLE_W-1:0]   o_play_byte
);

    logic                                win_sel;      // host inside $d000..$d3ff
    logic [BUF_ADDR_W-1:0]               mem_addr;     // byte address into the buffer
    logic                                mem_cs;
    logic [BUS_LANES-1:0]                lane_we;
    logic [SAMPLE_W-1:0]                 lane_mem [BUS_LANES][2**(BUF_ADDR_W-1)];
    logic [BUS_LANES-1:0][SAMPLE_W-1:0]  lane_q;       // read latch per lane
    logic                                lane_sel_q;   // byte lane of the last read
    logic                                buf_rd_q;

    ////////////////////////////////////////////////////////////
    // decode and arbitration
    ////////////////////////////////////////////////////////////

    assign win_sel = (i_bus_addr[BUS_ADDR_W-1:BUF_WINDOW_BITS]
                      == BUF_BASE[BUS_ADDR_W-1:BUF_WINDOW_BITS]);

    // any host cycle, or just pointing at the window, holds off playback
    assign o_host_busy = i_bus_rd | (|i_bus_wr) | win_sel;

    // host owns the port when it addresses the window
    assign mem_addr = win_sel ? i_bus_addr[BUF_WINDOW_BITS-1:0] : i_play_addr;
    assign mem_cs   = (win_sel & i_bus_rd) | i_play_rd;
    assign lane_we  = {BUS_LANES{win_sel}} & i_bus_wr;

    ////////////////////////////////////////////////////////////
    // byte lane memories
    ////////////////////////////////////////////////////////////

    // word index is the byte address without bit 0
    always_ff @(posedge clk)
    begin
        for (int lane = 0; lane < BUS_LANES; lane++)
        begin
            if (lane_we[lane])
                lane_mem[lane][mem_addr[BUF_ADDR_W-1:1]] <=
                    i_bus_wdata[lane*SAMPLE_W +: SAMPLE_W];
            if (mem_cs)
                lane_q[lane] <= lane_mem[lane][mem_addr[BUF_ADDR_W-1:1]];
        end
        if (mem_cs)
            lane_sel_q <= mem_addr[0];
    end

    assign o_play_byte = lane_q[lane_sel_q];    // odd bytes live in the high lane

    ////////////////////////////////////////////////////////////
    // host read gating
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            buf_rd_q <= 1'b0;
        else
            buf_rd_q <= win_sel & i_bus_rd;
    end

    assign o_buf_rdata = buf_rd_q ? lane_q : '0;   // word, both lanes

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // fsm must never steal the port from the host
    a_no_collision: assert property (
        @(posedge clk) disable iff (!reset_n)
        i_play_rd |-> !win_sel
    );

endmodule

/* hdl/wav_player_top.sv */
// wav player top level
`timescale 1ns/1ps

module wav_player_top
    import bus_pkg::*;
    import wav_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    // host bus
    input  logic [BUS_ADDR_W-1:0] i_bus_addr,
    input  logic [BUS_LANES-1:0]  i_bus_wr,
    input  logic                  i_bus_rd,
    input  logic [BUS_DATA_W-1:0] i_bus_wdata,
    output logic [BUS_DATA_W-1:0] o_bus_rdata,

    // audio
    output logic [SAMPLE_W-1:0]   o_wav_sample
);

    // control
    logic                  ctl_wr;
    logic                  enable;
    logic                  active_half;
    rate_sel_t             rate;
    logic [BUS_DATA_W-1:0] ctl_rdata;

    // playback path
    logic                  tick;
    logic                  half_wrap;
    logic                  host_busy;
    logic                  play_rd;
    logic [BUF_ADDR_W-1:0] play_addr;
    logic [SAMPLE_W-1:0]   play_byte;
    logic [BUS_DATA_W-1:0] buf_rdata;

    // each source is zero when not selected
    assign o_bus_rdata = buf_rdata | ctl_rdata;

    ////////////////////////////////////////////////////////////
    // instances
    ////////////////////////////////////////////////////////////

    wav_ctl_regs i_wav_ctl_regs (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_bus_addr    (i_bus_addr),
        .i_bus_wr      (i_bus_wr),
        .i_bus_rd      (i_bus_rd),
        .i_bus_wdata   (i_bus_wdata),
        .i_half_wrap   (half_wrap),
        .o_ctl_wr      (ctl_wr),
        .o_enable      (enable),
        .o_active_half (active_half),
        .o_rate        (rate),
        .o_ctl_rdata   (ctl_rdata)
    );

    sample_rate_divider i_sample_rate_divider (
        .clk     (clk),
        .reset_n (reset_n),
        .i_rate  (rate),
        .o_tick  (tick)
    );

    sample_fetch_fsm i_sample_fetch_fsm (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_tick        (tick),
        .i_enable      (enable),
        .i_ctl_wr      (ctl_wr),
        .i_active_half (active_half),
        .i_host_busy   (host_busy),
        .i_play_byte   (play_byte),
        .o_play_rd     (play_rd),
        .o_play_addr   (play_addr),
        .o_half_wrap   (half_wrap),
        .o_wav_sample  (o_wav_sample)
    );

    sample_buffer i_sample_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_bus_addr  (i_bus_addr),
        .i_bus_wr    (i_bus_wr),
        .i_bus_rd    (i_bus_rd),
        .i_bus_wdata (i_bus_wdata),
        .i_play_rd   (play_rd),
        .i_play_addr (play_addr),
        .o_host_busy (host_busy),
        .o_buf_rdata (buf_rdata),
        .o_play_byte (play_byte)
    );

endmodule

/* dv/wav_player_tb.sv */
// wav player testbench
`timescale 1ns/1ps

module wav_player_tb
    import bus_pkg::*;
();

    logic        clk;
    logic        reset_n;
    logic [15:0] bus_addr;
    logic [1:0]  bus_wr;
    logic        bus_rd;
    logic [15:0] bus_wdata;
    logic [15:0] bus_rdata;
    logic [7:0]  wav_sample;

    logic [7:0]  buf_model [1024];      // flat {half, pos} image of the buffer
    logic [8:0]  model_pos;
    logic        model_half;
    int          divs [4] = '{544, 1088, 500, 500};    // clocks per tick, by rate code
    integer      seed = 19172;
    integer      cycle = 0;             // rising edges seen
    integer      last_update = 0;       // edge of the last sample update
    integer      checks = 0;
    integer      errors = 0;
    integer      tests = 0;
    integer      test_errors = 0;

    wav_player_top i_wav_player_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_bus_addr   (bus_addr),
        .i_bus_wr     (bus_wr),
        .i_bus_rd     (bus_rd),
        .i_bus_wdata  (bus_wdata),
        .o_bus_rdata  (bus_rdata),
        .o_wav_sample (wav_sample)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;             // 25 MHz stand-in for the 24 MHz clock
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // read data stays zero unless a read was strobed the cycle before
    a_rdata_gated: assert property (
        @(posedge clk) disable iff (!reset_n)
        !$past(bus_rd) |-> (bus_rdata == 16'h0000)
    ) else
    begin
        errors = errors + 1;
        $display("read data was not zero in a cycle without a preceding read strobe");
    end

    ////////////////////////////////////////////////////////////
    // bus and model helpers
    ////////////////////////////////////////////////////////////

    task automatic step_cycle();
        @(posedge clk);
        #1;                             // drive and sample just after the edge
    endtask

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks = checks + 1;
        assert (act === exp)
        else
        begin
            errors = errors + 1;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic write_bus(input logic [15:0] addr, input logic [1:0] lanes,
                             input logic [15:0] data);
        bus_addr  = addr;
        bus_wr    = lanes;
        bus_wdata = data;
        step_cycle();                   // write lands on this edge
        bus_addr  = 16'h0000;           // park outside the window
        bus_wr    = 2'b00;
    endtask

    task automatic read_bus(input logic [15:0] addr, output logic [15:0] data);
        bus_addr = addr;
        bus_rd   = 1'b1;
        step_cycle();
        bus_addr = 16'h0000;
        bus_rd   = 1'b0;
        data     = bus_rdata;           // one cycle after the strobe
    endtask

    // random fill, each byte differs from the one played before it
    task automatic fill_buffer();
        for (int i = 0; i < 1024; i++)
        begin
            buf_model[i] = $random(seed);
            while (i > 0 && (buf_model[i] == buf_model[i-1] ||
                   (i == 1 && buf_model[i] == wav_sample)))
                buf_model[i] = buf_model[i] + 8'd1;
        end
        for (int w = 0; w < 512; w++)
            write_bus(BUF_BASE + 16'(2 * w), 2'b11, {buf_model[2*w+1], buf_model[2*w]});
    endtask

    task automatic advance_model(output logic [7:0] exp);
        model_pos = model_pos + 1'b1;
        if (model_pos == 9'd0)
            model_half = ~model_half;   // wrap hands playback to the other half
        exp = buf_model[{model_half, model_pos}];
    endtask

    task automatic wait_sample(input logic [7:0] exp, input int limit);
        int n;
        n = 0;
        while (wav_sample !== exp && n < limit)
        begin
            step_cycle();
            n++;
        end
        if (wav_sample !== exp)
        begin
            errors = errors + 1;
            $display("timed out after %0d cycles waiting for sample %h", limit, exp);
        end
        last_update = cycle;
    endtask

    // first sample by value, the rest exactly one divisor apart
    task automatic play_samples(input string name, input int count, input int div);
        logic [7:0] prev;
        logic [7:0] exp;
        advance_model(exp);
        wait_sample(exp, div + 8);
        for (int k = 1; k < count; k++)
        begin
            prev = exp;
            advance_model(exp);
            while (cycle < last_update + div - 1)
                step_cycle();
            compare({name, " hold"}, prev, wav_sample);
            step_cycle();
            compare({name, " update"}, exp, wav_sample);
            last_update = cycle;
        end
    endtask

    task automatic finish_test(input string name);
        tests = tests + 1;
        $display("test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        logic [15:0] rdata;
        logic [15:0] addr;
        logic [15:0] wdata;
        logic [7:0]  exp;
        logic [7:0]  hold_val;
        logic [3:0]  ctl_vals [4];
        int          n;

        ctl_vals  = '{4'h2, 4'h4, 4'hE, 4'h8};     // enable bit always clear
        reset_n   = 1'b0;
        bus_addr  = 16'h0000;
        bus_wr    = 2'b00;
        bus_rd    = 1'b0;
        bus_wdata = 16'h0000;
        step_cycle();
        step_cycle();
        reset_n = 1'b1;

        compare("reset sample", 16'h0000, wav_sample);
        read_bus(WAVCTL_ADDR, rdata);
        compare("reset control", 16'h0000, rdata);
        finish_test("reset");

        for (int i = 0; i < 4; i++)
        begin
            write_bus(WAVCTL_ADDR, 2'b11, 16'hA5F0 | 16'(ctl_vals[i]));  // upper bits dropped
            read_bus(WAVCTL_ADDR, rdata);
            compare("control readback", 16'(ctl_vals[i]), rdata);
        end
        write_bus(WAVCTL_ADDR, 2'b01, 16'h0000);
        finish_test("control");

        for (int i = 0; i < 8; i++)
        begin
            addr  = BUF_BASE | (16'($random(seed)) & 16'h03FE);
            wdata = $random(seed);
            write_bus(addr, 2'b11, wdata);
            read_bus(addr, rdata);
            compare("buffer word", wdata, rdata);
        end
        write_bus(BUF_BASE + 16'h0010, 2'b11, 16'h1234);
        write_bus(BUF_BASE + 16'h0010, 2'b01, 16'hFFAB);   // low lane only
        read_bus(BUF_BASE + 16'h0010, rdata);
        compare("buffer low lane", 16'h12AB, rdata);
        write_bus(BUF_BASE + 16'h0010, 2'b10, 16'hCDFF);   // high lane only
        read_bus(BUF_BASE + 16'h0011, rdata);              // odd byte reads the same word
        compare("buffer high lane", 16'hCDAB, rdata);
        finish_test("buffer");

        for (int r = 0; r < 4; r++)
        begin
            fill_buffer();
            write_bus(WAVCTL_ADDR, 2'b01, 16'(r << 2) | 16'h0001);    // half A, enabled
            model_pos  = 9'd0;
            model_half = 1'b0;
            play_samples("playback", 4, divs[r]);
            write_bus(WAVCTL_ADDR, 2'b01, 16'h0000);
        end
        finish_test("playback");

        fill_buffer();
        write_bus(WAVCTL_ADDR, 2'b01, 16'h0001);   // 44100
        model_pos  = 9'd0;
        model_half = 1'b0;
        play_samples("backpressure", 1, 544);
        hold_val = buf_model[{model_half, model_pos}];  // byte now on the output
        advance_model(exp);                         // this tick lands under the held read
        while (cycle < last_update + 10)
            step_cycle();
        bus_rd = 1'b1;                              // address 0, no port selected
        while (cycle < last_update + 564)
        begin
            step_cycle();
            compare("backpressure hold", hold_val, wav_sample);
        end
        bus_rd = 1'b0;
        n = 0;
        while (wav_sample !== exp && n < 2)
        begin
            step_cycle();
            n++;
        end
        compare("backpressure release", exp, wav_sample);
        write_bus(WAVCTL_ADDR, 2'b01, 16'h0000);
        finish_test("backpressure");

        fill_buffer();
        write_bus(WAVCTL_ADDR, 2'b01, 16'h0009);   // 48000, half A
        model_pos  = 9'd0;
        model_half = 1'b0;
        play_samples("half switch A", 511, 500);
        play_samples("half switch wrap", 1, 500);   // position 0 of half B
        read_bus(WAVCTL_ADDR, rdata);
        compare("half switch control", 16'h000B, rdata);
        play_samples("half switch B", 3, 500);
        write_bus(WAVCTL_ADDR, 2'b01, 16'h0000);
        finish_test("half switch");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* sim.f */
hdl/bus_pkg.sv
hdl/wav_pkg.sv
hdl/sample_rate_divider.sv
hdl/wav_ctl_regs.sv
hdl/sample_fetch_fsm.sv
hdl/sample_buffer.sv
hdl/wav_player_top.sv
dv/wav_player_tb.sv
